// ==== include/bp_macros.svh ====
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// ======================================================================
// branch predictor sizing
// ======================================================================

// fetch slots looked up together each cycle
`define BP_QSLOTS 4

// top bit of an instruction address
`define BP_AMSB 31

// number of two-bit counters in the pattern table
`define BP_BHT_DEPTH 512

// global history length, the upper two bits take part in the index
`define BP_HIST_BITS 3

// resolved-branch queue entries, kept a power of two so pointers wrap
`define BP_QUEUE_DEPTH 32

`endif

// ==== rtl/bp_pkg.sv ====
`include "bp_macros.svh"

package bp_pkg;

	// instruction address
	typedef logic [`BP_AMSB:0] addr_t;

	// two-bit counter in the wrapped encoding
	// 0 weak taken, 1 strong taken, 2 strong not taken, 3 weak not taken
	typedef logic [1:0] ctr_t;

	// pattern table index
	typedef logic [$clog2(`BP_BHT_DEPTH)-1:0] bht_idx_t;

	// global branch history, newest outcome in bit 0
	typedef logic [`BP_HIST_BITS-1:0] hist_t;

	// outcome queue pointer
	typedef logic [$clog2(`BP_QUEUE_DEPTH)-1:0] qptr_t;

	// table index shared by the fetch lookup and the commit update
	// word address bits 8:2 on top, two oldest history bits below
	function automatic bht_idx_t bht_index(input addr_t ip, input hist_t gh);
		return {ip[8:2], gh[`BP_HIST_BITS-1 -: 2]};
	endfunction

endpackage

// ==== rtl/branch_predictor.sv ====
`timescale 1ns/1ps
`include "bp_macros.svh"

module branch_predictor (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  en,
	input  logic [1:0]            rsv_valid,
	input  bp_pkg::addr_t [1:0]   rsv_ip,
	input  logic [1:0]            rsv_taken,
	input  bp_pkg::addr_t         fetch_ip [`BP_QSLOTS],
	output logic [`BP_QSLOTS-1:0] predict_taken
);
	import bp_pkg::*;

	// queue to updater
	logic upd_valid;
	addr_t upd_ip;
	logic upd_taken;

	// updater to table
	logic wr_en;
	bht_idx_t wr_idx;
	ctr_t wr_ctr;
	ctr_t wr_cur;

	// history into the fetch lookup
	hist_t ghist;

	// fetch lookup against the table
	bht_idx_t rd_idx [`BP_QSLOTS];
	ctr_t rd_ctr [`BP_QSLOTS];

	// ==================================================================
	// commit side
	// ==================================================================
	outcome_queue u_queue (
		.clk       (clk),
		.rst       (rst),
		.rsv_valid (rsv_valid),
		.rsv_ip    (rsv_ip),
		.rsv_taken (rsv_taken),
		.upd_valid (upd_valid),
		.upd_ip    (upd_ip),
		.upd_taken (upd_taken)
	);

	history_updater u_updater (
		.clk       (clk),
		.rst       (rst),
		.en        (en),
		.upd_valid (upd_valid),
		.upd_taken (upd_taken),
		.upd_ip    (upd_ip),
		.wr_cur    (wr_cur),
		.ghist     (ghist),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_ctr    (wr_ctr)
	);

	// ==================================================================
	// shared counter table and fetch side
	// ==================================================================
	pattern_table u_table (
		.clk    (clk),
		.rst    (rst),
		.rd_idx (rd_idx),
		.rd_ctr (rd_ctr),
		.wr_en  (wr_en),
		.wr_idx (wr_idx),
		.wr_ctr (wr_ctr),
		.wr_cur (wr_cur)
	);

	fetch_predict u_predict (
		.en            (en),
		.fetch_ip      (fetch_ip),
		.ghist         (ghist),
		.rd_idx        (rd_idx),
		.rd_ctr        (rd_ctr),
		.predict_taken (predict_taken)
	);

endmodule

// ==== rtl/fetch_predict.sv ====
`timescale 1ns/1ps
`include "bp_macros.svh"

module fetch_predict (
	input  logic                   en,
	input  bp_pkg::addr_t          fetch_ip [`BP_QSLOTS],
	input  bp_pkg::hist_t          ghist,
	output bp_pkg::bht_idx_t       rd_idx [`BP_QSLOTS],
	input  bp_pkg::ctr_t           rd_ctr [`BP_QSLOTS],
	output logic [`BP_QSLOTS-1:0]  predict_taken
);
	import bp_pkg::*;

	// ==================================================================
	// per-slot lookup
	// ==================================================================
	always_comb begin
		for (int s = 0; s < `BP_QSLOTS; s++) begin
			// same index rule as the commit-side update
			rd_idx[s] = bht_index(fetch_ip[s], ghist);
			// counter values 0 and 1 are the taken half
			// so the upper bit clear means taken
			// en low forces every slot to not taken
			predict_taken[s] = en && !rd_ctr[s][1];
		end
	end

endmodule

// ==== rtl/history_updater.sv ====
`timescale 1ns/1ps
`include "bp_macros.svh"

module history_updater (
	input  logic             clk,
	input  logic             rst,
	input  logic             en,
	input  logic             upd_valid,
	input  logic             upd_taken,
	input  bp_pkg::addr_t    upd_ip,
	input  bp_pkg::ctr_t     wr_cur,
	output bp_pkg::hist_t    ghist,
	output logic             wr_en,
	output bp_pkg::bht_idx_t wr_idx,
	output bp_pkg::ctr_t     wr_ctr
);
	import bp_pkg::*;

	// ==================================================================
	// write index and strobe
	// ==================================================================

	// index uses the history as it was before this outcome shifts in
	assign wr_idx = bht_index(upd_ip, ghist);

	// drained entries are only applied while the predictor is enabled
	// anything drained with en low is simply lost
	assign wr_en = upd_valid && en;

	// ==================================================================
	// saturating step in the wrapped encoding
	// ==================================================================
	always_comb begin
		if (upd_taken) begin
			// taken walks 2 -> 3 -> 0 -> 1 and sticks at 1
			if (wr_cur == ctr_t'(1))
				wr_ctr = wr_cur;
			else
				wr_ctr = wr_cur + ctr_t'(1);
		end else begin
			// not taken walks 1 -> 0 -> 3 -> 2 and sticks at 2
			if (wr_cur == ctr_t'(2))
				wr_ctr = wr_cur;
			else
				wr_ctr = wr_cur - ctr_t'(1);
		end
	end

	// ==================================================================
	// global history
	// ==================================================================

	// newest outcome enters at bit 0, oldest drops off the top
	// shifts on the same condition as the table write
	always_ff @(posedge clk) begin
		if (rst) begin
			ghist <= '0;
		end else if (wr_en) begin
			ghist <= {ghist[`BP_HIST_BITS-2:0], upd_taken};
		end
	end

endmodule

// ==== rtl/outcome_queue.sv ====
`timescale 1ns/1ps
`include "bp_macros.svh"

module outcome_queue (
	input  logic                clk,
	input  logic                rst,
	input  logic [1:0]          rsv_valid,
	input  bp_pkg::addr_t [1:0] rsv_ip,
	input  logic [1:0]          rsv_taken,
	output logic                upd_valid,
	output bp_pkg::addr_t       upd_ip,
	output logic                upd_taken
);
	import bp_pkg::*;

	// occupancy counter needs one bit more than a pointer to hold full
	localparam int CW = $clog2(`BP_QUEUE_DEPTH) + 1;
	localparam logic [CW-1:0] QD = CW'(`BP_QUEUE_DEPTH);

	// entry storage, address and resolved direction side by side
	addr_t ent_ip [`BP_QUEUE_DEPTH];
	logic [`BP_QUEUE_DEPTH-1:0] ent_taken;

	qptr_t head;
	qptr_t tail;
	logic [CW-1:0] count;

	logic acc0;
	logic acc1;
	logic pop;
	logic [1:0] n_push;
	qptr_t wptr1;

	// ==================================================================
	// push and pop decisions
	// ==================================================================
	always_comb begin
		// slot 0 goes first, slot 1 only if room remains after it
		acc0 = rsv_valid[0] && (count < QD);
		acc1 = rsv_valid[1] && ((count + CW'(acc0)) < QD);
		n_push = {1'b0, acc0} + {1'b0, acc1};
		// one entry leaves per cycle whenever anything is queued
		pop = (count != '0);
		// slot 1 lands right behind slot 0 when both are taken
		wptr1 = tail + qptr_t'(acc0);
	end

	// entry writes, up to two per cycle
	always_ff @(posedge clk) begin
		if (acc0) begin
			ent_ip[tail] <= rsv_ip[0];
			ent_taken[tail] <= rsv_taken[0];
		end
		if (acc1) begin
			ent_ip[wptr1] <= rsv_ip[1];
			ent_taken[wptr1] <= rsv_taken[1];
		end
	end

	// ==================================================================
	// pointers, occupancy and drain strobe
	// ==================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			upd_valid <= 1'b0;
		end else begin
			tail <= tail + qptr_t'(n_push);
			count <= count + CW'(n_push) - CW'(pop);
			// valid for exactly the cycle after the dequeue
			upd_valid <= pop;
			if (pop)
				head <= head + qptr_t'(1);
		end
	end

	// dequeued entry held for the updater
	always_ff @(posedge clk) begin
		if (pop) begin
			upd_ip <= ent_ip[head];
			upd_taken <= ent_taken[head];
		end
	end

endmodule

// ==== rtl/pattern_table.sv ====
`timescale 1ns/1ps
`include "bp_macros.svh"

module pattern_table (
	input  logic             clk,
	input  logic             rst,
	input  bp_pkg::bht_idx_t rd_idx [`BP_QSLOTS],
	output bp_pkg::ctr_t     rd_ctr [`BP_QSLOTS],
	input  logic             wr_en,
	input  bp_pkg::bht_idx_t wr_idx,
	input  bp_pkg::ctr_t     wr_ctr,
	output bp_pkg::ctr_t     wr_cur
);
	import bp_pkg::*;

	// ==================================================================
	// counter array
	// ==================================================================

	// one two-bit counter per history/address pair
	ctr_t bht [`BP_BHT_DEPTH];

	// reset sweeps every counter to weak not taken
	// otherwise a single write port from the commit side
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `BP_BHT_DEPTH; i++)
				bht[i] <= ctr_t'(3);
		end else if (wr_en) begin
			bht[wr_idx] <= wr_ctr;
		end
	end

	// ==================================================================
	// read ports
	// ==================================================================
	always_comb begin
		// fetch lookups, all slots in the same cycle
		for (int s = 0; s < `BP_QSLOTS; s++)
			rd_ctr[s] = bht[rd_idx[s]];
		// current value under the update index
		// feeds the saturating step in the updater
		wr_cur = bht[wr_idx];
	end

endmodule

// ==== tb.f ====
+incdir+include
rtl/bp_pkg.sv
rtl/outcome_queue.sv
rtl/pattern_table.sv
rtl/history_updater.sv
rtl/fetch_predict.sv
rtl/branch_predictor.sv
test/bp_checker.sv
test/tb_branch_predictor.sv

// ==== test/bp_checker.sv ====
`timescale 1ns/1ps
`include "bp_macros.svh"

module bp_checker (
	input logic                                clk,
	input logic                                rst,
	input logic                                en,
	input logic                                upd_valid,
	input logic                                wr_en,
	input logic [$clog2(`BP_QUEUE_DEPTH):0]   occ,
	input bp_pkg::hist_t                       ghist
);
	import bp_pkg::*;

	// ==================================================================
	// queue and update strobes
	// ==================================================================

	// occupancy counter stays within the queue size
	occ_in_range: assert property (@(posedge clk) disable iff (rst)
		occ <= `BP_QUEUE_DEPTH)
		else $error("outcome queue occupancy above its depth");

	// table write only for a drained entry while enabled
	wr_needs_valid: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> (upd_valid && en))
		else $error("table write without a drained entry and en");

	// ==================================================================
	// reset state
	// ==================================================================
	rst_clears_valid: assert property (@(posedge clk) rst |=> !upd_valid)
		else $error("upd_valid high right after a reset cycle");

	// history back to zero after reset
	rst_clears_hist: assert property (@(posedge clk) rst |=> (ghist == '0))
		else $error("global history not cleared by reset");

endmodule

// ==== test/tb_branch_predictor.sv ====
`timescale 1ns/1ps
`include "bp_macros.svh"

module tb_branch_predictor;
	import bp_pkg::*;

	// word addresses of the few branches used, bits 8:2 of the address
	localparam logic [6:0] WA = 7'h10;
	localparam logic [6:0] WB = 7'h21;
	localparam logic [6:0] WC = 7'h33;
	localparam logic [6:0] WD = 7'h45;
	localparam logic [6:0] WE = 7'h52;

	// one table row plus what the model expects from it
	typedef struct {
		string name;
		logic en;
		logic [1:0] v;
		addr_t ip0;
		addr_t ip1;
		logic [1:0] tk;
		addr_t f [`BP_QSLOTS];
		logic [`BP_QSLOTS-1:0] exp_pred;
		ctr_t exp_ctr [`BP_QSLOTS];
		int nd;
	} row_t;

	logic clk = 1'b0;
	logic rst;
	logic en;
	logic [1:0] rsv_valid;
	addr_t [1:0] rsv_ip;
	logic [1:0] rsv_taken;
	addr_t fetch_ip [`BP_QSLOTS];
	logic [`BP_QSLOTS-1:0] predict_taken;

	row_t rows[$];
	integer seed = 32'h7fe0_f722;
	int cycles = 0;
	int limit = 100;

	// reference model state
	ctr_t mctr [`BP_BHT_DEPTH];
	hist_t mhist;
	addr_t mq_ip[$];
	logic mq_tk[$];

	branch_predictor dut0 (
		.clk           (clk),
		.rst           (rst),
		.en            (en),
		.rsv_valid     (rsv_valid),
		.rsv_ip        (rsv_ip),
		.rsv_taken     (rsv_taken),
		.fetch_ip      (fetch_ip),
		.predict_taken (predict_taken)
	);

	bind branch_predictor bp_checker chk0 (
		.clk       (clk),
		.rst       (rst),
		.en        (en),
		.upd_valid (upd_valid),
		.wr_en     (wr_en),
		.occ       (u_queue.count),
		.ghist     (ghist)
	);

	always #50 clk = ~clk;

	// ==================================================================
	// reference model
	// ==================================================================

	// address bits 8:2 above the two oldest history bits
	function automatic bht_idx_t ref_index(input addr_t ip, input hist_t h);
		return {ip[8:2], h[2:1]};
	endfunction

	// taken walks 2 to 3 to 0 to 1 and holds at 1
	// not taken walks back and holds at 2
	function automatic ctr_t ref_step(input ctr_t c, input logic t);
		case (c)
			2'd2: return t ? 2'd3 : 2'd2;
			2'd3: return t ? 2'd0 : 2'd2;
			2'd0: return t ? 2'd1 : 2'd3;
			default: return t ? 2'd1 : 2'd0;
		endcase
	endfunction

	// upper address bits and byte offset are random
	// only bits 8:2 reach the index
	function automatic addr_t mk_ip(input logic [6:0] w);
		logic [31:0] r;
		r = $random(seed);
		return {r[`BP_AMSB:9], w, r[1:0]};
	endfunction

	task automatic add_row(input string name, input logic e, input logic [1:0] v,
			input logic [6:0] w0, input logic t0, input logic [6:0] w1, input logic t1,
			input logic [6:0] f0, input logic [6:0] f1, input logic [6:0] f2,
			input logic [6:0] f3);
		row_t r;
		bht_idx_t ix;
		r.name = name;
		r.en = e;
		r.v = v;
		r.ip0 = mk_ip(w0);
		r.ip1 = mk_ip(w1);
		r.tk = {t1, t0};
		r.f[0] = mk_ip(f0);
		r.f[1] = mk_ip(f1);
		r.f[2] = mk_ip(f2);
		r.f[3] = mk_ip(f3);
		// slot 0 enters the queue ahead of slot 1
		if (v[0]) begin
			mq_ip.push_back(r.ip0);
			mq_tk.push_back(t0);
		end
		if (v[1]) begin
			mq_ip.push_back(r.ip1);
			mq_tk.push_back(t1);
		end
		r.nd = mq_ip.size();
		// one entry per cycle and lost when en is low
		while (mq_ip.size() > 0) begin
			addr_t ip;
			logic tk;
			ip = mq_ip.pop_front();
			tk = mq_tk.pop_front();
			if (e) begin
				ix = ref_index(ip, mhist);
				mctr[ix] = ref_step(mctr[ix], tk);
				mhist = {mhist[1:0], tk};
			end
		end
		for (int s = 0; s < `BP_QSLOTS; s++) begin
			ix = ref_index(r.f[s], mhist);
			r.exp_ctr[s] = mctr[ix];
			r.exp_pred[s] = e && (mctr[ix] == 2'd0 || mctr[ix] == 2'd1);
		end
		rows.push_back(r);
	endtask

	// ==================================================================
	// checks and failure exit
	// ==================================================================
	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_predict(input string name, input logic [`BP_QSLOTS-1:0] exp,
			input logic [`BP_QSLOTS-1:0] act);
		if (act !== exp) begin
			$display("ERR %s predict_taken expected %b actual %b", name, exp, act);
			report_failure("prediction vector mismatch");
		end
	endtask

	task automatic check_counter(input string name, input int slot, input ctr_t exp,
			input ctr_t act);
		if (act !== exp) begin
			$display("ERR %s slot %0d counter expected %0d actual %0d", name, slot, exp, act);
			report_failure("counter value mismatch");
		end
	endtask

	// cycle limit follows the table length
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit)
			report_failure("timeout: the test table did not finish in time");
	end

	// ==================================================================
	// stimulus
	// ==================================================================
	initial begin
		rst = 1'b1;
		en = 1'b1;
		rsv_valid = 2'b00;
		rsv_ip = '0;
		rsv_taken = 2'b00;
		for (int s = 0; s < `BP_QSLOTS; s++)
			fetch_ip[s] = '0;
		for (int i = 0; i < `BP_BHT_DEPTH; i++)
			mctr[i] = 2'd3;
		mhist = '0;

		add_row("reset_state",       1, 2'b00, WA, 0, WA, 0, WA, WB, WC, WD);
		add_row("warm_history",      1, 2'b11, WA, 1, WA, 1, WA, WB, WC, WD);
		add_row("train_taken",       1, 2'b11, WA, 1, WA, 1, WA, WB, WC, WD);
		add_row("keep_taken",        1, 2'b01, WA, 1, WA, 0, WA, WB, WC, WD);
		add_row("keep_taken_again",  1, 2'b01, WA, 1, WA, 0, WA, WA, WB, WB);
		add_row("untrain_not_taken", 1, 2'b11, WA, 0, WA, 0, WA, WB, WC, WD);
		add_row("history_select_a",  1, 2'b01, WB, 1, WA, 0, WA, WB, WC, WD);
		add_row("history_select_b",  1, 2'b01, WB, 0, WA, 0, WA, WB, WC, WD);
		add_row("slot_order",        1, 2'b11, WB, 1, WA, 1, WA, WB, WC, WE);
		add_row("slot_order_mixed",  1, 2'b11, WA, 0, WB, 1, WA, WB, WC, WE);
		add_row("en_low",            0, 2'b11, WA, 0, WA, 0, WA, WB, WC, WD);
		add_row("en_low_drain",      0, 2'b01, WB, 1, WB, 0, WA, WB, WC, WD);
		add_row("en_restored",       1, 2'b00, WA, 0, WA, 0, WA, WB, WC, WD);
		add_row("mixed_slots",       1, 2'b11, WC, 1, WC, 1, WA, WC, WE, WB);
		add_row("mixed_slots_more",  1, 2'b11, WC, 1, WE, 0, WC, WE, WA, WD);
		limit = rows.size() * 40 + 100;

		repeat (4) @(posedge clk);
		#1 rst = 1'b0;

		foreach (rows[i]) begin
			@(posedge clk);
			#1;
			en = rows[i].en;
			rsv_valid = rows[i].v;
			rsv_ip[0] = rows[i].ip0;
			rsv_ip[1] = rows[i].ip1;
			rsv_taken = rows[i].tk;
			@(posedge clk);
			#1 rsv_valid = 2'b00;
			// drain time from the model queue plus three settle cycles
			repeat (rows[i].nd + 3) @(posedge clk);
			#1;
			for (int s = 0; s < `BP_QSLOTS; s++)
				fetch_ip[s] = rows[i].f[s];
			// combinational predictions settle well before the falling edge
			@(negedge clk);
			check_predict(rows[i].name, rows[i].exp_pred, predict_taken);
			for (int s = 0; s < `BP_QSLOTS; s++)
				check_counter(rows[i].name, s, rows[i].exp_ctr[s], dut0.rd_ctr[s]);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
